// File: rtl/mpc_challenge_pkg.sv
////////////////////////////////////////////////////////////
// types shared by the challenge fsm, counter and buffers
////////////////////////////////////////////////////////////
`default_nettype none

package mpc_challenge_pkg;

    localparam int WORD_W = 32;

    // one seed word or one hash output word
    typedef logic [WORD_W-1:0] word_t;

    typedef enum logic [2:0] {
        s_idle       = 3'd0,
        s_load_h1    = 3'd1,
        s_start_hash = 3'd2,
        s_load_r     = 3'd3,
        s_load_eps   = 3'd4,
        s_finish     = 3'd5
    } challenge_state_e;

    // terminal flags from load_counter
    typedef struct packed {
        logic h1_last;
        logic word_last;
        logic entry_last;
    } cnt_status_t;

    // strobes toward the hash/XOF core
    typedef struct packed {
        logic start;
        logic out_ready;
        logic force_done;
    } hash_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/word_ram.sv
////////////////////////////////////////////////////////////
// single-port RAM with registered read and any payload type
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [31:0]
) (
    input  wire logic                     i_clk,
    input  wire logic                     i_we,
    input  wire logic [$clog2(DEPTH)-1:0] i_addr,
    input  wire payload_t                 i_data,
    output payload_t                      o_q
);

    payload_t mem [DEPTH];

    // read returns the old contents on a write to the same address
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_data;
        end
        o_q <= mem[i_addr];
    end

endmodule

`default_nettype wire

// File: rtl/load_counter.sv
////////////////////////////////////////////////////////////
// seed address, word-in-entry and entry counters with flags
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module load_counter import mpc_challenge_pkg::*; #(
    parameter int LAMBDA  = 128,
    parameter int T       = 3,
    parameter int TAU     = 17,
    parameter int D_SPLIT = 1
) (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst,
    input  wire logic                             i_h1_inc,
    input  wire logic                             i_h1_clr,
    input  wire logic                             i_word_inc,
    input  wire logic                             i_cnt_clr,
    output logic [$clog2(2*LAMBDA/32)-1:0]        o_h1_addr,
    output logic [$clog2(TAU*D_SPLIT)-1:0]        o_entry_addr,
    output cnt_status_t                           o_status
);

    localparam int H1_WORDS  = 2 * LAMBDA / 32;
    localparam int H1_AW     = $clog2(H1_WORDS);
    localparam int N_ENTRIES = TAU * D_SPLIT;
    localparam int E_AW      = $clog2(N_ENTRIES);
    localparam int WC_W      = (T > 1) ? $clog2(T) : 1;

    logic [WC_W-1:0] word_cnt;

    // terminal compares on the registered counts
    assign o_status.h1_last    = (o_h1_addr == H1_AW'(H1_WORDS - 1));
    assign o_status.word_last  = (word_cnt == WC_W'(T - 1));
    assign o_status.entry_last = (o_entry_addr == E_AW'(N_ENTRIES - 1));

    // seed address, clear wins over increment
    always_ff @(posedge i_clk) begin
        if (i_rst || i_cnt_clr || i_h1_clr) begin
            o_h1_addr <= '0;
        end else if (i_h1_inc) begin
            o_h1_addr <= o_h1_addr + 1'b1;
        end
    end

    // word count modulo T, entry count modulo TAU*D_SPLIT
    always_ff @(posedge i_clk) begin
        if (i_rst || i_cnt_clr) begin
            word_cnt     <= '0;
            o_entry_addr <= '0;
        end else if (i_word_inc) begin
            if (o_status.word_last) begin
                word_cnt <= '0;
                // wraps to 0 between the r and eps stores
                if (o_status.entry_last) begin
                    o_entry_addr <= '0;
                end else begin
                    o_entry_addr <= o_entry_addr + 1'b1;
                end
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/challenge_fsm.sv
////////////////////////////////////////////////////////////
// sequences seed load, hash start, r and eps loads and done
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module challenge_fsm import mpc_challenge_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_start,
    input  wire logic        i_hash_valid,
    input  wire cnt_status_t i_status,
    output logic             o_h1_rd,
    output logic             o_h1_inc,
    output logic             o_h1_clr,
    output logic             o_word_inc,
    output logic             o_cnt_clr,
    output logic             o_fill_r,
    output logic             o_fill_eps,
    output hash_ctrl_t       o_hash_ctrl,
    output logic             o_done
);

    challenge_state_e state;
    logic             entry_done;
    logic             store_done;

    // a word that closes the last entry of the current store
    assign entry_done = o_word_inc && i_status.word_last;
    assign store_done = entry_done && i_status.entry_last;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= s_idle;
        end else begin
            unique case (state)
                s_idle: begin
                    if (i_start) begin
                        state <= i_status.h1_last ? s_start_hash : s_load_h1;
                    end
                end
                s_load_h1: begin
                    if (i_status.h1_last) begin
                        state <= s_start_hash;
                    end
                end
                s_start_hash: begin
                    state <= s_load_r;
                end
                s_load_r: begin
                    if (store_done) begin
                        state <= s_load_eps;
                    end
                end
                s_load_eps: begin
                    if (store_done) begin
                        state <= s_finish;
                    end
                end
                s_finish: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // address 0 goes out in the same cycle that samples start
    assign o_h1_rd  = (state == s_load_h1) || (state == s_idle && i_start);
    assign o_h1_inc = o_h1_rd;
    assign o_h1_clr = o_h1_rd && i_status.h1_last;

    assign o_fill_r   = (state == s_load_r);
    assign o_fill_eps = (state == s_load_eps);

    assign o_hash_ctrl.start      = (state == s_start_hash);
    assign o_hash_ctrl.out_ready  = o_fill_r || o_fill_eps;
    assign o_hash_ctrl.force_done = (state == s_finish);

    // accept only while the core is told we are ready
    assign o_word_inc = o_hash_ctrl.out_ready && i_hash_valid;

    // counters are left clean for the next run
    assign o_cnt_clr = (state == s_finish);
    assign o_done    = (state == s_finish);

endmodule

`default_nettype wire

// File: rtl/seed_buffer.sv
////////////////////////////////////////////////////////////
// h1 seed store, filled from the source and read by the hash
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module seed_buffer import mpc_challenge_pkg::*; #(
    parameter int LAMBDA = 128
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_h1_rd,
    input  wire logic [$clog2(2*LAMBDA/32)-1:0] i_h1_addr,
    input  wire word_t                         i_h1,
    input  wire logic                          i_hash_rd,
    input  wire logic [$clog2(2*LAMBDA/32)-1:0] i_hash_addr,
    output word_t                              o_hash_data
);

    localparam int H1_WORDS = 2 * LAMBDA / 32;
    localparam int H1_AW    = $clog2(H1_WORDS);

    logic [H1_AW-1:0] wr_addr;
    logic             wr_en;
    logic [H1_AW-1:0] ram_addr;

    // source data arrives one cycle after its address
    always_ff @(posedge i_clk) begin
        wr_addr <= i_h1_addr;
        wr_en   <= i_h1_rd;
    end

    assign ram_addr = i_hash_rd ? i_hash_addr : wr_addr;

    word_ram #(
        .DEPTH     (H1_WORDS),
        .payload_t (word_t)
    ) seed_ram_i (
        .i_clk  (i_clk),
        .i_we   (wr_en && !i_hash_rd),
        .i_addr (ram_addr),
        .i_data (i_h1),
        .o_q    (o_hash_data)
    );

endmodule

`default_nettype wire

// File: rtl/challenge_buffer.sv
////////////////////////////////////////////////////////////
// packs hash words into T-word entries for the r and eps stores
// each store has its own host read port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module challenge_buffer import mpc_challenge_pkg::*; #(
    parameter int T       = 3,
    parameter int TAU     = 17,
    parameter int D_SPLIT = 1
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_accept,
    input  wire word_t                          i_hash_data,
    input  wire logic                           i_word_last,
    input  wire logic                           i_fill_r,
    input  wire logic                           i_fill_eps,
    input  wire logic [$clog2(TAU*D_SPLIT)-1:0] i_entry_addr,
    input  wire logic                           i_r_rd,
    input  wire logic [$clog2(TAU*D_SPLIT)-1:0] i_r_addr,
    output word_t [T-1:0]                       o_r,
    input  wire logic                           i_eps_rd,
    input  wire logic [$clog2(TAU*D_SPLIT)-1:0] i_eps_addr,
    output word_t [T-1:0]                       o_eps
);

    localparam int N_ENTRIES = TAU * D_SPLIT;
    localparam int E_AW      = $clog2(N_ENTRIES);

    typedef word_t [T-1:0] entry_t;

    entry_t          packer;
    logic            wr_r;
    logic            wr_eps;
    logic [E_AW-1:0] wr_addr;

    // shift in at the bottom so the first word ends up on top
    always_ff @(posedge i_clk) begin
        if (i_accept) begin
            for (int i = T - 1; i > 0; i--) begin
                packer[i] <= packer[i-1];
            end
            packer[0] <= i_hash_data;
        end
    end

    // write the full entry one cycle after its last word
    always_ff @(posedge i_clk) begin
        wr_r    <= i_accept && i_word_last && i_fill_r;
        wr_eps  <= i_accept && i_word_last && i_fill_eps;
        wr_addr <= i_entry_addr;
    end

    word_ram #(
        .DEPTH     (N_ENTRIES),
        .payload_t (entry_t)
    ) r_ram_i (
        .i_clk  (i_clk),
        .i_we   (wr_r),
        .i_addr (i_r_rd ? i_r_addr : wr_addr),
        .i_data (packer),
        .o_q    (o_r)
    );

    word_ram #(
        .DEPTH     (N_ENTRIES),
        .payload_t (entry_t)
    ) eps_ram_i (
        .i_clk  (i_clk),
        .i_we   (wr_eps),
        .i_addr (i_eps_rd ? i_eps_addr : wr_addr),
        .i_data (packer),
        .o_q    (o_eps)
    );

endmodule

`default_nettype wire

// File: rtl/expand_mpc_challenge.sv
////////////////////////////////////////////////////////////
// challenge expansion top, h1 in, hash stream out to r and eps
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module expand_mpc_challenge import mpc_challenge_pkg::*; #(
    parameter int LAMBDA  = 128,
    parameter int T       = 3,
    parameter int TAU     = 17,
    parameter int D_SPLIT = 1
) (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst,
    input  wire logic                            i_start,
    output logic                                 o_done,
    // h1 source memory
    output logic [$clog2(2*LAMBDA/32)-1:0]       o_h1_addr,
    output logic                                 o_h1_rd,
    input  wire word_t                           i_h1,
    // hash core
    input  wire logic [$clog2(2*LAMBDA/32)-1:0]  i_hash_addr,
    input  wire logic                            i_hash_rd,
    output word_t                                o_hash_data,
    input  wire word_t                           i_hash_data,
    input  wire logic                            i_hash_valid,
    output hash_ctrl_t                           o_hash_ctrl,
    // host read ports
    input  wire logic [$clog2(TAU*D_SPLIT)-1:0]  i_r_addr,
    input  wire logic                            i_r_rd,
    output word_t [T-1:0]                        o_r,
    input  wire logic [$clog2(TAU*D_SPLIT)-1:0]  i_eps_addr,
    input  wire logic                            i_eps_rd,
    output word_t [T-1:0]                        o_eps
);

    logic                           h1_inc;
    logic                           h1_clr;
    logic                           word_inc;
    logic                           cnt_clr;
    logic                           fill_r;
    logic                           fill_eps;
    cnt_status_t                    status;
    logic [$clog2(TAU*D_SPLIT)-1:0] entry_addr;

    challenge_fsm challenge_fsm_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_hash_valid (i_hash_valid),
        .i_status     (status),
        .o_h1_rd      (o_h1_rd),
        .o_h1_inc     (h1_inc),
        .o_h1_clr     (h1_clr),
        .o_word_inc   (word_inc),
        .o_cnt_clr    (cnt_clr),
        .o_fill_r     (fill_r),
        .o_fill_eps   (fill_eps),
        .o_hash_ctrl  (o_hash_ctrl),
        .o_done       (o_done)
    );

    load_counter #(
        .LAMBDA  (LAMBDA),
        .T       (T),
        .TAU     (TAU),
        .D_SPLIT (D_SPLIT)
    ) load_counter_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_h1_inc     (h1_inc),
        .i_h1_clr     (h1_clr),
        .i_word_inc   (word_inc),
        .i_cnt_clr    (cnt_clr),
        .o_h1_addr    (o_h1_addr),
        .o_entry_addr (entry_addr),
        .o_status     (status)
    );

    seed_buffer #(
        .LAMBDA (LAMBDA)
    ) seed_buffer_i (
        .i_clk       (i_clk),
        .i_h1_rd     (o_h1_rd),
        .i_h1_addr   (o_h1_addr),
        .i_h1        (i_h1),
        .i_hash_rd   (i_hash_rd),
        .i_hash_addr (i_hash_addr),
        .o_hash_data (o_hash_data)
    );

    challenge_buffer #(
        .T       (T),
        .TAU     (TAU),
        .D_SPLIT (D_SPLIT)
    ) challenge_buffer_i (
        .i_clk        (i_clk),
        .i_accept     (word_inc),
        .i_hash_data  (i_hash_data),
        .i_word_last  (status.word_last),
        .i_fill_r     (fill_r),
        .i_fill_eps   (fill_eps),
        .i_entry_addr (entry_addr),
        .i_r_rd       (i_r_rd),
        .i_r_addr     (i_r_addr),
        .o_r          (o_r),
        .i_eps_rd     (i_eps_rd),
        .i_eps_addr   (i_eps_addr),
        .o_eps        (o_eps)
    );

endmodule

`default_nettype wire

// File: tests/expand_mpc_challenge_properties.sv
////////////////////////////////////////////////////////////
// strobe checks bound into the challenge fsm
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module expand_mpc_challenge_properties import mpc_challenge_pkg::*; (
    input wire logic       i_clk,
    input wire logic       i_rst,
    input wire logic       o_h1_rd,
    input wire logic       o_done,
    input wire hash_ctrl_t o_hash_ctrl
);

    start_one_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_hash_ctrl.start |=> !o_hash_ctrl.start
    ) else $error("hash start held longer than one cycle");

    force_done_one_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_hash_ctrl.force_done |=> !o_hash_ctrl.force_done
    ) else $error("force_done held longer than one cycle");

    done_with_force_done: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_done == o_hash_ctrl.force_done
    ) else $error("done and force_done out of step");

    // seed load and stream phases never overlap
    no_ready_in_load: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(o_hash_ctrl.out_ready && o_h1_rd)
    ) else $error("out_ready raised during the seed load");

    quiet_in_reset: assert property (
        @(posedge i_clk)
        (i_rst && $past(i_rst)) |-> (o_hash_ctrl == '0 && !o_done && !o_h1_rd)
    ) else $error("strobe active during reset");

endmodule

bind challenge_fsm expand_mpc_challenge_properties fsm_properties_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_h1_rd     (o_h1_rd),
    .o_done      (o_done),
    .o_hash_ctrl (o_hash_ctrl)
);

`default_nettype wire

// File: tests/tb_expand_mpc_challenge.sv
////////////////////////////////////////////////////////////
// testbench for the challenge expansion, acts as h1 memory,
// hash core and host, and checks three runs against a model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_expand_mpc_challenge import mpc_challenge_pkg::*; ();

    localparam int LAMBDA         = 128;
    localparam int T              = 3;
    localparam int TAU            = 17;
    localparam int D_SPLIT        = 1;
    localparam int RUNS           = 3;
    localparam int H1_WORDS       = 2 * LAMBDA / 32;
    localparam int H1_AW          = $clog2(H1_WORDS);
    localparam int N_ENTRIES      = TAU * D_SPLIT;
    localparam int E_AW           = $clog2(N_ENTRIES);
    localparam int N_WORDS        = 2 * T * N_ENTRIES;
    localparam int TIMEOUT_CYCLES = RUNS * (H1_WORDS + 4 * N_WORDS + 50);

    typedef word_t [T-1:0] entry_t;

    localparam hash_ctrl_t CTRL_IDLE  = '{start: 1'b0, out_ready: 1'b0, force_done: 1'b0};
    localparam hash_ctrl_t CTRL_START = '{start: 1'b1, out_ready: 1'b0, force_done: 1'b0};
    localparam hash_ctrl_t CTRL_READY = '{start: 1'b0, out_ready: 1'b1, force_done: 1'b0};
    localparam hash_ctrl_t CTRL_DONE  = '{start: 1'b0, out_ready: 1'b0, force_done: 1'b1};

    logic             i_clk;
    logic             i_rst;
    logic             i_start;
    logic             o_done;
    logic [H1_AW-1:0] o_h1_addr;
    logic             o_h1_rd;
    word_t            i_h1;
    logic [H1_AW-1:0] i_hash_addr;
    logic             i_hash_rd;
    word_t            o_hash_data;
    word_t            i_hash_data;
    logic             i_hash_valid;
    hash_ctrl_t       o_hash_ctrl;
    logic [E_AW-1:0]  i_r_addr;
    logic             i_r_rd;
    entry_t           o_r;
    logic [E_AW-1:0]  i_eps_addr;
    logic             i_eps_rd;
    entry_t           o_eps;

    integer seed        = 83713;
    int     errors      = 0;
    int     failed_runs = 0;
    int     cycles;

    expand_mpc_challenge #(
        .LAMBDA  (LAMBDA),
        .T       (T),
        .TAU     (TAU),
        .D_SPLIT (D_SPLIT)
    ) expand_mpc_challenge_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .o_done       (o_done),
        .o_h1_addr    (o_h1_addr),
        .o_h1_rd      (o_h1_rd),
        .i_h1         (i_h1),
        .i_hash_addr  (i_hash_addr),
        .i_hash_rd    (i_hash_rd),
        .o_hash_data  (o_hash_data),
        .i_hash_data  (i_hash_data),
        .i_hash_valid (i_hash_valid),
        .o_hash_ctrl  (o_hash_ctrl),
        .i_r_addr     (i_r_addr),
        .i_r_rd       (i_r_rd),
        .o_r          (o_r),
        .i_eps_addr   (i_eps_addr),
        .i_eps_rd     (i_eps_rd),
        .o_eps        (o_eps)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_entry(input string name, input entry_t got, input entry_t exp);
        if (got !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_ctrl(input string name, input hash_ctrl_t got, input hash_ctrl_t exp);
        if (got !== exp) begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // one full run through seed load, hash start, stream, done and host readback
    task automatic run_once(input int run);
        word_t  h1_mem[$];
        word_t  stream[$];
        word_t  hash_q[$];
        entry_t exp_r[$];
        entry_t exp_eps[$];
        entry_t e;
        int     ph;
        int     h1_idx;
        int     h1_addr;
        int     rd_idx;
        int     accepted;
        int     err_before;
        int     seed_chk_addr;
        int     host_chk_addr;
        int     eps_chk_addr;
        bit     seed_chk_v;
        bit     host_chk_v;
        bit     eps_chk_v;

        err_before = errors;
        for (int i = 0; i < H1_WORDS; i++) begin
            h1_mem.push_back($random(seed));
        end
        // a few extra words stay on offer after done
        for (int i = 0; i < N_WORDS + 8; i++) begin
            stream.push_back($random(seed));
        end
        hash_q = stream;
        // first word of a group ends up as the top word of the entry
        for (int k = 0; k < 2 * N_ENTRIES; k++) begin
            e = '0;
            for (int j = 0; j < T; j++) begin
                e = (e << 32) | entry_t'(stream[k * T + j]);
            end
            if (k < N_ENTRIES) begin
                exp_r.push_back(e);
            end else begin
                exp_eps.push_back(e);
            end
        end

        // phases 0 load h1, 1 start, 2 stream, 3 done, 4 over
        ph            = 0;
        h1_idx        = 0;
        h1_addr       = 0;
        rd_idx        = 0;
        accepted      = 0;
        seed_chk_v    = 1'b0;
        seed_chk_addr = 0;
        @(negedge i_clk);
        i_start = 1'b1;
        while (ph != 4) begin
            @(posedge i_clk);
            if (seed_chk_v) begin
                check_word($sformatf("o_hash_data[%0d]", seed_chk_addr), o_hash_data,
                           h1_mem[seed_chk_addr]);
            end
            seed_chk_v    = i_hash_rd;
            seed_chk_addr = int'(i_hash_addr);
            check_word("o_h1_rd", word_t'(o_h1_rd), word_t'(ph == 0));
            check_word("o_done", word_t'(o_done), word_t'(ph == 3));
            case (ph)
                0: begin
                    check_word("o_h1_addr", word_t'(o_h1_addr), word_t'(h1_idx));
                    check_ctrl("o_hash_ctrl", o_hash_ctrl, CTRL_IDLE);
                    h1_addr = int'(o_h1_addr);
                    h1_idx++;
                    if (h1_idx == H1_WORDS) begin
                        ph = 1;
                    end
                end
                1: begin
                    check_ctrl("o_hash_ctrl", o_hash_ctrl, CTRL_START);
                    ph = 2;
                end
                2: begin
                    check_ctrl("o_hash_ctrl", o_hash_ctrl, CTRL_READY);
                    // core moves on only when it sees ready with its valid
                    if (i_hash_valid && o_hash_ctrl.out_ready) begin
                        void'(hash_q.pop_front());
                        accepted++;
                        if (accepted == N_WORDS) begin
                            ph = 3;
                        end
                    end
                end
                default: begin
                    check_ctrl("o_hash_ctrl", o_hash_ctrl, CTRL_DONE);
                    ph = 4;
                end
            endcase
            @(negedge i_clk);
            i_start      = 1'b0;
            i_h1         = h1_mem[h1_addr];
            i_hash_rd    = (ph == 2) && (rd_idx < H1_WORDS);
            i_hash_addr  = H1_AW'(rd_idx);
            if (i_hash_rd) begin
                rd_idx++;
            end
            i_hash_valid = (ph >= 2) && (($random(seed) & 3) != 0);
            i_hash_data  = hash_q[0];
        end

        // host readback while the core keeps offering words
        // eps is read one cycle later and in reverse order
        host_chk_v    = 1'b0;
        host_chk_addr = 0;
        eps_chk_v     = 1'b0;
        eps_chk_addr  = 0;
        for (int c = 0; c < N_ENTRIES + 3; c++) begin
            @(posedge i_clk);
            check_ctrl("o_hash_ctrl", o_hash_ctrl, CTRL_IDLE);
            check_word("o_done", word_t'(o_done), '0);
            if (host_chk_v) begin
                check_entry($sformatf("o_r[%0d]", host_chk_addr), o_r, exp_r[host_chk_addr]);
            end
            if (eps_chk_v) begin
                check_entry($sformatf("o_eps[%0d]", eps_chk_addr), o_eps,
                            exp_eps[eps_chk_addr]);
            end
            host_chk_v    = i_r_rd;
            host_chk_addr = int'(i_r_addr);
            eps_chk_v     = i_eps_rd;
            eps_chk_addr  = int'(i_eps_addr);
            @(negedge i_clk);
            i_r_rd       = (c < N_ENTRIES);
            i_r_addr     = E_AW'(c);
            i_eps_rd     = (c >= 1) && (c <= N_ENTRIES);
            i_eps_addr   = i_eps_rd ? E_AW'(N_ENTRIES - c) : '0;
            i_hash_valid = (($random(seed) & 3) != 0);
        end
        i_hash_valid = 1'b0;

        if (errors == err_before) begin
            $display("run %0d passed, %0d words accepted", run, accepted);
        end else begin
            failed_runs++;
            $display("run %0d failed with %0d errors", run, errors - err_before);
        end
    endtask

    // watchdog sized from the run length
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a run never reached done", cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        i_rst        = 1'b1;
        i_start      = 1'b0;
        i_h1         = '0;
        i_hash_addr  = '0;
        i_hash_rd    = 1'b0;
        i_hash_data  = '0;
        i_hash_valid = 1'b0;
        i_r_addr     = '0;
        i_r_rd       = 1'b0;
        i_eps_addr   = '0;
        i_eps_rd     = 1'b0;
        repeat (10) @(negedge i_clk);
        i_rst = 1'b0;
        for (int run = 0; run < RUNS; run++) begin
            run_once(run);
        end
        $display("%0d runs, %0d passed, %0d failed, %0d errors",
                 RUNS, RUNS - failed_runs, failed_runs, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/mpc_challenge_pkg.sv
rtl/word_ram.sv
rtl/load_counter.sv
rtl/challenge_fsm.sv
rtl/seed_buffer.sv
rtl/challenge_buffer.sv
rtl/expand_mpc_challenge.sv
tests/expand_mpc_challenge_properties.sv
tests/tb_expand_mpc_challenge.sv

// File: Makefile
TOP = tb_expand_mpc_challenge

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
